// File: rtl/cp0_cfg.svh
`ifndef CP0_CFG_SVH
`define CP0_CFG_SVH

// CP0 register numbers, as seen by MTC0/MFC0.
`define CP0_REG_BADVADDR 5'd8
`define CP0_REG_COUNT    5'd9
`define CP0_REG_COMPARE  5'd11
`define CP0_REG_STATUS   5'd12
`define CP0_REG_CAUSE    5'd13
`define CP0_REG_EPC      5'd14

// Cause.ExcCode values.
`define EXCCODE_INT  5'h00
`define EXCCODE_ADEL 5'h04
`define EXCCODE_ADES 5'h05
`define EXCCODE_SYS  5'h08
`define EXCCODE_BP   5'h09
`define EXCCODE_RI   5'h0a
`define EXCCODE_OV   5'h0c

// Exception entry points.
`define EXC_VEC_BOOT   32'hbfc0_0380 // BEV=1.
`define EXC_VEC_NORMAL 32'h8000_0180 // BEV=0.

// CU0 and BEV set, interrupts off.
`define CP0_STATUS_RESET 32'h1040_0000

// Software-writable bits.
`define CP0_STATUS_WMASK 32'h0000_ff07 // IM, ERL, EXL, IE.
`define CP0_CAUSE_WMASK  32'h0000_0300 // Software interrupts IP[1:0].

`endif

// File: rtl/cp0_pkg.sv
`default_nettype none

`include "cp0_cfg.svh"

package cp0_pkg;

	typedef enum logic [4:0] {
		EXC_INT  = `EXCCODE_INT,
		EXC_ADEL = `EXCCODE_ADEL,
		EXC_ADES = `EXCCODE_ADES,
		EXC_SYS  = `EXCCODE_SYS,
		EXC_BP   = `EXCCODE_BP,
		EXC_RI   = `EXCCODE_RI,
		EXC_OV   = `EXCCODE_OV
	} exc_code_t;

	// Status, bit 31 down to bit 0.
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [3:0] cu;
			logic [4:0] rsv0;   // RP, FR, RE, MX, PX.
			logic       bev;
			logic [5:0] rsv1;   // TS, SR, NMI and zeros.
			logic [7:0] im;
			logic [2:0] rsv2;   // KX, SX, UX.
			logic       um;
			logic       rsv3;
			logic       erl;
			logic       exl;
			logic       ie;
		} fields;
	} cp0_status_t;

	// Cause, bit 31 down to bit 0.
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic        bd;
			logic        ti;
			logic [1:0]  ce;
			logic [11:0] rsv0;  // DC, PCI, IV, WP and zeros.
			logic [7:0]  ip;
			logic        rsv1;
			exc_code_t   exc_code;
			logic [1:0]  rsv2;
		} fields;
	} cp0_cause_t;

endpackage

`default_nettype wire

// File: rtl/cp0_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "cp0_cfg.svh"

module cp0_regs
	import cp0_pkg::*;
(
	input  wire              clk,
	input  wire              rst,

	input  wire  [4:0]       raddr1,
	input  wire  [4:0]       raddr2,
	output logic [31:0]      rdata1,
	output logic [31:0]      rdata2,

	input  wire              wen,
	input  wire  [4:0]       waddr,
	input  wire  [31:0]      wdata,

	input  wire  [5:0]       int_req,

	input  wire              exc_flush,
	input  wire              exc_eret,
	input  wire              exc_delayslot,
	input  wire  [31:0]      exc_pc,
	input  wire  exc_code_t  exc_code,
	input  wire              exc_badvaddr_we,
	input  wire  [31:0]      exc_badvaddr,

	output cp0_status_t      status,
	output cp0_cause_t       cause,
	output logic [31:0]      epc
);

	logic [31:0] badvaddr_q;
	logic [31:0] count_q;
	logic [31:0] compare_q;
	logic [31:0] epc_q;
	cp0_status_t status_q;
	cp0_cause_t  cause_q;

	logic [31:0] badvaddr_d;
	logic [31:0] count_d;
	logic [31:0] compare_d;
	logic [31:0] epc_d;
	cp0_status_t status_d;
	cp0_cause_t  cause_d;

	// The exception unit sees the committed state only.
	assign status = status_q;
	assign cause  = cause_q;
	assign epc    = epc_q;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			badvaddr_q     <= 32'h0;
			count_q        <= 32'h0;
			compare_q      <= 32'h0;
			epc_q          <= 32'h0;
			status_q.raw   <= `CP0_STATUS_RESET;
			cause_q.raw    <= 32'h0;
		end
		else
		begin
			badvaddr_q <= badvaddr_d;
			count_q    <= count_d;
			compare_q  <= compare_d;
			epc_q      <= epc_d;
			status_q   <= status_d;
			cause_q    <= cause_d;
		end
	end

	always_comb
	begin
		badvaddr_d = badvaddr_q;
		compare_d  = compare_q;
		epc_d      = epc_q;
		status_d   = status_q;
		cause_d    = cause_q;

		count_d = count_q + 32'd1;             // Free-running timer.
		cause_d.fields.ip[7:2] = int_req;      // Hardware lines, sampled as levels.

		// MTC0.
		if (wen)
		begin
			case (waddr)
				`CP0_REG_COUNT:   count_d = wdata;
				`CP0_REG_COMPARE:
				begin
					compare_d         = wdata;
					cause_d.fields.ti = 1'b0;  // Acknowledges the timer.
				end
				`CP0_REG_STATUS:
					status_d.raw = (status_d.raw & ~`CP0_STATUS_WMASK)
						| (wdata & `CP0_STATUS_WMASK);
				`CP0_REG_CAUSE:
					cause_d.raw = (cause_d.raw & ~`CP0_CAUSE_WMASK)
						| (wdata & `CP0_CAUSE_WMASK);
				`CP0_REG_EPC:     epc_d = wdata;
				default: ;                       // BadVAddr is read-only.
			endcase
		end

		// Timer interrupt stays pending until Compare is rewritten.
		if (count_d == compare_d)
			cause_d.fields.ti = 1'b1;
		cause_d.fields.ip[7] = int_req[5] | cause_d.fields.ti;

		if (exc_flush)
		begin
			if (exc_eret)
			begin
				if (status_d.fields.erl)
					status_d.fields.erl = 1'b0;
				else
					status_d.fields.exl = 1'b0;
			end
			else
			begin
				// A nested exception keeps the first return address.
				if (!status_d.fields.exl)
				begin
					epc_d             = exc_delayslot ? exc_pc - 32'd4 : exc_pc;
					cause_d.fields.bd = exc_delayslot;
				end
				status_d.fields.exl      = 1'b1;
				cause_d.fields.exc_code  = exc_code;
				if (exc_badvaddr_we)
					badvaddr_d = exc_badvaddr;
			end
		end
	end

	function automatic logic [31:0] read_reg(input logic [4:0] addr);
		case (addr)
			`CP0_REG_BADVADDR: read_reg = badvaddr_d;
			`CP0_REG_COUNT:    read_reg = count_d;
			`CP0_REG_COMPARE:  read_reg = compare_d;
			`CP0_REG_STATUS:   read_reg = status_d.raw;
			`CP0_REG_CAUSE:    read_reg = cause_d.raw;
			`CP0_REG_EPC:      read_reg = epc_d;
			default:           read_reg = 32'h0;
		endcase
	endfunction

	// Reads bypass the registers and return this cycle's update.
	always_comb
	begin
		rdata1 = read_reg(raddr1);
		rdata2 = read_reg(raddr2);
	end

endmodule

`default_nettype wire

// File: rtl/except_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cp0_cfg.svh"

module except_unit
	import cp0_pkg::*;
(
	input  wire              mem_valid,
	input  wire  [31:0]      mem_pc,
	input  wire              mem_delayslot,
	input  wire              if_adel,
	input  wire              ri,
	input  wire              ov,
	input  wire              syscall,
	input  wire              brk,
	input  wire              data_adel,
	input  wire              data_ades,
	input  wire              eret,
	input  wire  [31:0]      mem_badaddr,

	input  wire  cp0_status_t status,
	input  wire  cp0_cause_t  cause,
	input  wire  [31:0]      epc,

	output logic             exc_flush,
	output logic             exc_eret,
	output logic             exc_delayslot,
	output logic [31:0]      exc_pc,
	output exc_code_t        exc_code,
	output logic             exc_badvaddr_we,
	output logic [31:0]      exc_badvaddr,
	output logic [31:0]      flush_pc
);

	logic int_enabled;
	logic int_pending;

	// Interrupts are only taken on a live instruction outside exception level.
	assign int_enabled = status.fields.ie & ~status.fields.exl & ~status.fields.erl;
	assign int_pending = mem_valid & int_enabled
		& (|(cause.fields.ip & status.fields.im));

	// Fixed priority, highest first.
	always_comb
	begin
		exc_flush       = 1'b0;
		exc_eret        = 1'b0;
		exc_code        = EXC_INT;
		exc_badvaddr_we = 1'b0;
		exc_badvaddr    = mem_badaddr;

		if (int_pending)
			exc_flush = 1'b1;
		else if (mem_valid)
		begin
			exc_flush = 1'b1;
			if (if_adel)
			begin
				exc_code        = EXC_ADEL;
				exc_badvaddr_we = 1'b1;
				exc_badvaddr    = mem_pc;        // Fetch fault reports the PC.
			end
			else if (ri)
				exc_code = EXC_RI;
			else if (ov)
				exc_code = EXC_OV;
			else if (syscall)
				exc_code = EXC_SYS;
			else if (brk)
				exc_code = EXC_BP;
			else if (data_adel)
			begin
				exc_code        = EXC_ADEL;
				exc_badvaddr_we = 1'b1;
			end
			else if (data_ades)
			begin
				exc_code        = EXC_ADES;
				exc_badvaddr_we = 1'b1;
			end
			else if (eret)
				exc_eret = 1'b1;
			else
				exc_flush = 1'b0;              // Plain instruction.
		end
	end

	assign exc_pc        = mem_pc;
	assign exc_delayslot = mem_delayslot;

	// Redirect target.
	always_comb
	begin
		if (exc_eret)
			flush_pc = epc;
		else if (status.fields.bev)
			flush_pc = `EXC_VEC_BOOT;
		else
			flush_pc = `EXC_VEC_NORMAL;
	end

endmodule

`default_nettype wire

// File: rtl/cp0_top.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_top
	import cp0_pkg::*;
(
	input  wire         clk,
	input  wire         rst,

	input  wire         wen,          // MTC0 write.
	input  wire  [4:0]  waddr,
	input  wire  [31:0] wdata,
	input  wire  [4:0]  raddr1,
	input  wire  [4:0]  raddr2,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2,

	input  wire  [5:0]  int_req,

	input  wire         mem_valid,    // Memory-stage instruction.
	input  wire  [31:0] mem_pc,
	input  wire         mem_delayslot,
	input  wire         if_adel,
	input  wire         ri,
	input  wire         ov,
	input  wire         syscall,
	input  wire         brk,
	input  wire         data_adel,
	input  wire         data_ades,
	input  wire         eret,
	input  wire  [31:0] mem_badaddr,

	output logic        flush,
	output logic [31:0] flush_pc,
	output logic        exc_level
);

	logic        exc_flush;
	logic        exc_eret;
	logic        exc_delayslot;
	logic [31:0] exc_pc;
	exc_code_t   exc_code;
	logic        exc_badvaddr_we;
	logic [31:0] exc_badvaddr;
	cp0_status_t status;
	cp0_cause_t  cause;
	logic [31:0] epc;

	assign flush     = exc_flush;
	assign exc_level = status.fields.exl;

	except_unit u_except (
		.mem_valid       (mem_valid),
		.mem_pc          (mem_pc),
		.mem_delayslot   (mem_delayslot),
		.if_adel         (if_adel),
		.ri              (ri),
		.ov              (ov),
		.syscall         (syscall),
		.brk             (brk),
		.data_adel       (data_adel),
		.data_ades       (data_ades),
		.eret            (eret),
		.mem_badaddr     (mem_badaddr),
		.status          (status),
		.cause           (cause),
		.epc             (epc),
		.exc_flush       (exc_flush),
		.exc_eret        (exc_eret),
		.exc_delayslot   (exc_delayslot),
		.exc_pc          (exc_pc),
		.exc_code        (exc_code),
		.exc_badvaddr_we (exc_badvaddr_we),
		.exc_badvaddr    (exc_badvaddr),
		.flush_pc        (flush_pc)
	);

	cp0_regs u_regs (
		.clk             (clk),
		.rst             (rst),
		.raddr1          (raddr1),
		.raddr2          (raddr2),
		.rdata1          (rdata1),
		.rdata2          (rdata2),
		.wen             (wen),
		.waddr           (waddr),
		.wdata           (wdata),
		.int_req         (int_req),
		.exc_flush       (exc_flush),
		.exc_eret        (exc_eret),
		.exc_delayslot   (exc_delayslot),
		.exc_pc          (exc_pc),
		.exc_code        (exc_code),
		.exc_badvaddr_we (exc_badvaddr_we),
		.exc_badvaddr    (exc_badvaddr),
		.status          (status),
		.cause           (cause),
		.epc             (epc)
	);

endmodule

`default_nettype wire

// File: testbench/cp0_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "cp0_cfg.svh"

module cp0_properties (
	input wire        clk,
	input wire        rst,
	input wire        mem_valid,
	input wire        exc_flush,
	input wire        exc_eret,
	input wire        exl,
	input wire        wen,
	input wire [4:0]  waddr,
	input wire [31:0] epc,
	input wire [31:0] count
);

	// A flush always belongs to a live memory-stage instruction.
	a_flush_needs_valid: assert property (@(posedge clk) disable iff (rst)
		exc_flush |-> mem_valid)
		else $error("flush raised without mem_valid");

	// Nested exceptions keep the first return address.
	a_epc_hold_nested: assert property (@(posedge clk) disable iff (rst)
		(exc_flush && !exc_eret && exl && !(wen && waddr == `CP0_REG_EPC))
		|=> $stable(epc))
		else $error("EPC changed on a nested exception");

	a_count_increment: assert property (@(posedge clk) disable iff (rst)
		!(wen && waddr == `CP0_REG_COUNT) |=> (count == $past(count) + 32'd1))
		else $error("Count did not advance by one");

endmodule

// Attached at the top level, where the exception unit and the register block meet.
bind cp0_top cp0_properties u_props (
	.clk       (clk),
	.rst       (rst),
	.mem_valid (mem_valid),
	.exc_flush (exc_flush),
	.exc_eret  (exc_eret),
	.exl       (status.fields.exl),
	.wen       (wen),
	.waddr     (waddr),
	.epc       (epc),
	.count     (u_regs.count_q)
);

`default_nettype wire

// File: testbench/tb_cp0.sv
`timescale 1ns/1ps
`default_nettype none

`include "cp0_cfg.svh"

module tb_cp0;

	logic        clk;
	logic        rst;
	logic        wen;
	logic [4:0]  waddr;
	logic [31:0] wdata;
	logic [4:0]  raddr1;
	logic [4:0]  raddr2;
	wire  [31:0] rdata1;
	wire  [31:0] rdata2;
	logic [5:0]  int_req;
	logic        mem_valid;
	logic [31:0] mem_pc;
	logic        mem_delayslot;
	logic        if_adel;
	logic        ri;
	logic        ov;
	logic        syscall;
	logic        brk;
	logic        data_adel;
	logic        data_ades;
	logic        eret;
	logic [31:0] mem_badaddr;
	wire         flush;
	wire  [31:0] flush_pc;
	wire         exc_level;

	logic [31:0] lfsr_q;

	cp0_top DUT (
		.clk(clk), .rst(rst),
		.wen(wen), .waddr(waddr), .wdata(wdata),
		.raddr1(raddr1), .raddr2(raddr2), .rdata1(rdata1), .rdata2(rdata2),
		.int_req(int_req),
		.mem_valid(mem_valid), .mem_pc(mem_pc), .mem_delayslot(mem_delayslot),
		.if_adel(if_adel), .ri(ri), .ov(ov), .syscall(syscall), .brk(brk),
		.data_adel(data_adel), .data_ades(data_ades), .eret(eret),
		.mem_badaddr(mem_badaddr),
		.flush(flush), .flush_pc(flush_pc), .exc_level(exc_level)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Taps 32, 22, 2, 1; one step per bit.
	function automatic logic [31:0] get_random(input int nbits);
		logic        fb;
		logic [31:0] val;
		val = 32'h0;
		for (int i = 0; i < nbits; i++)
		begin
			fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			val    = {val[30:0], fb};
		end
		return val;
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected)
		begin
			$display("Some tests failed");
			$fatal(1, "** Error at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
		end
	endtask

	task automatic drive_idle();
		wen           = 1'b0;
		waddr         = 5'd0;
		wdata         = 32'h0;
		int_req       = 6'd0;
		mem_valid     = 1'b0;
		mem_pc        = 32'h0;
		mem_delayslot = 1'b0;
		if_adel       = 1'b0;
		ri            = 1'b0;
		ov            = 1'b0;
		syscall       = 1'b0;
		brk           = 1'b0;
		data_adel     = 1'b0;
		data_ades     = 1'b0;
		eret          = 1'b0;
		mem_badaddr   = 32'h0;
	endtask

	// Inputs change 1 ns after the edge.
	task automatic start_cycle();
		@(posedge clk);
		#1;
		drive_idle();
	endtask

	task automatic read_reg(input logic [4:0] addr, output logic [31:0] val);
		raddr1 = addr;
		#1;
		val = rdata1;
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [31:0] val);
		start_cycle();
		wen   = 1'b1;
		waddr = addr;
		wdata = val;
	endtask

	task automatic write_and_check(input logic [4:0] addr, input logic [31:0] val,
		input logic [31:0] expected, input string msg);
		logic [31:0] rd;
		write_reg(addr, val);
		start_cycle();
		read_reg(addr, rd);
		check_value(rd, expected, msg);
		raddr2 = addr;
		#1;
		check_value(rdata2, expected, {msg, " on port 2"});
	endtask

	// Flag order: if_adel, ri, ov, syscall, brk, data_adel, data_ades.
	task automatic raise(input logic [6:0] flags, input logic do_eret, input logic [31:0] pc,
		input logic ds, input logic [31:0] badaddr);
		start_cycle();
		mem_valid     = 1'b1;
		mem_pc        = pc;
		mem_delayslot = ds;
		mem_badaddr   = badaddr;
		{data_ades, data_adel, brk, syscall, ov, ri, if_adel} = flags;
		eret          = do_eret;
		#1;
	endtask

	function automatic logic [4:0] expected_code(input logic [6:0] flags);
		if (flags[0]) return 5'd4;
		if (flags[1]) return 5'd10;
		if (flags[2]) return 5'd12;
		if (flags[3]) return 5'd8;
		if (flags[4]) return 5'd9;
		if (flags[5]) return 5'd4;
		return 5'd5;
	endfunction

	task automatic test_reset_and_timer();
		logic [31:0] rd;
		logic [31:0] c0;
		start_cycle();
		read_reg(`CP0_REG_STATUS, rd);
		check_value(rd, 32'h1040_0000, "Status after reset");
		read_reg(`CP0_REG_CAUSE, rd);
		check_value(rd, 32'h0, "Cause after reset");
		read_reg(`CP0_REG_COUNT, c0);
		repeat (7) start_cycle();
		read_reg(`CP0_REG_COUNT, rd);
		check_value(rd, c0 + 32'd7, "Count after 7 cycles");

		// Compare five ticks ahead.
		start_cycle();
		read_reg(`CP0_REG_COUNT, c0);
		wen   = 1'b1;
		waddr = `CP0_REG_COMPARE;
		wdata = c0 + 32'd5;
		for (int i = 1; i <= 5; i++)
		begin
			start_cycle();
			read_reg(`CP0_REG_CAUSE, rd);
			check_value({31'd0, rd[30]}, (i == 5) ? 32'd1 : 32'd0, "Cause.TI on timer");
		end
		start_cycle();
		read_reg(`CP0_REG_COUNT, c0);
		wen   = 1'b1;
		waddr = `CP0_REG_COMPARE;
		wdata = c0 + 32'h0100_0000;
		read_reg(`CP0_REG_CAUSE, rd);
		check_value({31'd0, rd[30]}, 32'd0, "Cause.TI after Compare rewrite");
	endtask

	task automatic test_masked_writes();
		logic [31:0] w;
		logic [31:0] rd;
		for (int i = 0; i < 4; i++)
		begin
			w = get_random(32);
			write_and_check(`CP0_REG_STATUS, w,
				(32'h1040_0000 & ~32'h0000_ff07) | (w & 32'h0000_ff07), "Status masked write");
			w = get_random(32);
			write_and_check(`CP0_REG_CAUSE, w, w & 32'h0000_0300, "Cause masked write");
			w = get_random(32);
			write_and_check(`CP0_REG_EPC, w, w, "EPC write");
			w = get_random(32);
			write_and_check(`CP0_REG_COMPARE, w, w, "Compare write");
		end
		start_cycle();
		raddr2 = 5'd31;
		read_reg(5'd3, rd);
		check_value(rd, 32'h0, "Unmapped register 3");
		check_value(rdata2, 32'h0, "Unmapped register 31");
		read_reg(`CP0_REG_COUNT, rd);
		wen   = 1'b1;
		waddr = `CP0_REG_COMPARE;
		wdata = rd + 32'h0100_0000;       // Park the timer far away.
		write_reg(`CP0_REG_CAUSE, 32'h0);
		write_reg(`CP0_REG_STATUS, 32'h0);
	endtask

	task automatic take_and_check(input logic [6:0] flags, input logic ds, input string msg);
		logic [31:0] pc;
		logic [31:0] rd;
		pc = get_random(32);
		pc = {pc[31:2], 2'b00};
		write_reg(`CP0_REG_STATUS, 32'h0);
		raise(flags, 1'b0, pc, ds, 32'h0);
		check_value({31'd0, flush}, 32'd1, {msg, " flush"});
		check_value(flush_pc, `EXC_VEC_BOOT, {msg, " flush_pc"});
		read_reg(`CP0_REG_CAUSE, rd);
		check_value({27'd0, rd[6:2]}, {27'd0, expected_code(flags)}, {msg, " ExcCode"});
		check_value({31'd0, rd[31]}, {31'd0, ds}, {msg, " BD"});
		read_reg(`CP0_REG_EPC, rd);
		check_value(rd, ds ? pc - 32'd4 : pc, {msg, " EPC"});
		start_cycle();
		#1;
		check_value({31'd0, exc_level}, 32'd1, {msg, " exc_level"});
	endtask

	task automatic test_exception_entry();
		logic [31:0] w;
		for (int i = 0; i < 7; i++)
		begin
			take_and_check(7'd1 << i, 1'b0, "Single flag");
			take_and_check(7'd1 << i, 1'b1, "Single flag in delay slot");
		end
		for (int i = 0; i < 6; i++)
		begin
			w = get_random(7);
			if (w[6:0] == 7'd0)
				w = 32'd1;
			take_and_check(w[6:0], w[0], "Several flags");
		end
	endtask

	task automatic test_nested_exception();
		logic [31:0] pc1;
		logic [31:0] pc2;
		logic [31:0] rd;
		pc1 = get_random(32);
		pc2 = get_random(32);
		pc1 = {pc1[31:2], 2'b00};
		write_reg(`CP0_REG_STATUS, 32'h0);
		raise(7'b000_1000, 1'b0, pc1, 1'b0, 32'h0);    // Syscall.
		start_cycle();
		#1;
		check_value({31'd0, exc_level}, 32'd1, "EXL after first exception");
		raise(7'b000_0010, 1'b0, pc2, 1'b1, 32'h0);    // Reserved instruction.
		read_reg(`CP0_REG_CAUSE, rd);
		check_value({27'd0, rd[6:2]}, 32'd10, "Nested ExcCode");
		check_value({31'd0, rd[31]}, 32'd0, "Nested BD");
		read_reg(`CP0_REG_EPC, rd);
		check_value(rd, pc1, "Nested EPC");
	endtask

	task automatic test_addr_errors_eret();
		logic [31:0] a;
		logic [31:0] pc;
		logic [31:0] rd;
		pc = get_random(32);
		a  = get_random(32);
		raise(7'b010_0000, 1'b0, pc, 1'b0, a);
		read_reg(`CP0_REG_BADVADDR, rd);
		check_value(rd, a, "BadVAddr on load error");
		a = get_random(32);
		raise(7'b100_0000, 1'b0, pc, 1'b0, a);
		read_reg(`CP0_REG_BADVADDR, rd);
		check_value(rd, a, "BadVAddr on store error");
		a = get_random(32);
		raise(7'b000_0001, 1'b0, pc, 1'b0, a);
		read_reg(`CP0_REG_BADVADDR, rd);
		check_value(rd, pc, "BadVAddr on fetch error");

		a = get_random(32);
		write_reg(`CP0_REG_EPC, a);
		write_reg(`CP0_REG_STATUS, 32'h2);
		raise(7'd0, 1'b1, pc, 1'b0, 32'h0);
		check_value({31'd0, exc_level}, 32'd1, "EXL before ERET");
		check_value({31'd0, flush}, 32'd1, "ERET flush");
		check_value(flush_pc, a, "ERET flush_pc");
		start_cycle();
		#1;
		check_value({31'd0, exc_level}, 32'd0, "EXL after ERET");
	endtask

	task automatic expect_no_interrupt(input logic [31:0] status_val, input int j,
		input string msg);
		write_reg(`CP0_REG_STATUS, status_val);
		repeat (4)
		begin
			start_cycle();
			int_req   = 6'd1 << j;
			mem_valid = 1'b1;
			#1;
			check_value({31'd0, flush}, 32'd0, msg);
		end
		write_reg(`CP0_REG_STATUS, 32'h0);
	endtask

	task automatic test_interrupts();
		logic [31:0] rd;
		logic        seen;
		logic [31:0] im;
		for (int j = 0; j < 6; j++)
		begin
			im = 32'd1 << (10 + j);
			write_reg(`CP0_REG_STATUS, im | 32'd1);
			seen = 1'b0;
			for (int t = 0; t < 8 && !seen; t++)
			begin
				start_cycle();
				int_req   = 6'd1 << j;
				mem_valid = 1'b1;
				#1;
				if (flush)
				begin
					seen = 1'b1;
					read_reg(`CP0_REG_CAUSE, rd);
					check_value({27'd0, rd[6:2]}, 32'd0, "Interrupt ExcCode");
					check_value(flush_pc, `EXC_VEC_BOOT, "Interrupt flush_pc");
				end
			end
			if (!seen)
			begin
				$display("Some tests failed");
				$fatal(1, "Timed out waiting for the interrupt flush on line %0d", j);
			end
			start_cycle();
			write_reg(`CP0_REG_STATUS, 32'h0);
			expect_no_interrupt(im, j, "Interrupt with IE clear");
			expect_no_interrupt((32'd1 << (10 + (j + 1) % 6)) | 32'd1, j,
				"Interrupt with IM clear");
			expect_no_interrupt(im | 32'h3, j, "Interrupt with EXL set");
		end
	endtask

	initial
	begin
		lfsr_q = 32'h442f030a;
		raddr1 = 5'd0;
		raddr2 = 5'd0;
		drive_idle();
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		test_reset_and_timer();
		test_masked_writes();
		test_exception_entry();
		test_nested_exception();
		test_addr_errors_eret();
		test_interrupts();

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+rtl
rtl/cp0_pkg.sv
rtl/cp0_regs.sv
rtl/except_unit.sv
rtl/cp0_top.sv
testbench/cp0_properties.sv
testbench/tb_cp0.sv

// File: Makefile
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module tb_cp0 -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vtb_cp0

clean:
	rm -rf $(OBJ_DIR)
